/* logic/icache_pkg.sv */
`default_nettype none

package icache_pkg;

   // address and data widths of both bus ports
   localparam int ADDR_W = 32;
   localparam int WORD_W = 32;

   // one LRU bit per set only covers two ways
   localparam int NUM_WAYS = 2;

   // byte lane bits below the word offset
   localparam int BYTE_OFS_W = 2;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;

   // master to slave, read only so no we or sel
   typedef struct packed {
      logic  cyc;
      logic  stb;
      addr_t adr;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_rsp_t;

   // controller sequence
   typedef enum logic [1:0] {
      st_idle,
      st_lookup,
      st_refill,
      st_respond
   } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/cache_arrays.sv */
`default_nettype none
`timescale 1ns/10ps

module cache_arrays #(
   parameter int WORDS_PER_LINE = 16,
   parameter int NUM_SETS       = 32,
   localparam int INDEX_W    = $clog2(NUM_SETS),
   localparam int WORD_OFS_W = $clog2(WORDS_PER_LINE),
   localparam int TAG_W      = icache_pkg::ADDR_W - INDEX_W - WORD_OFS_W - icache_pkg::BYTE_OFS_W,
   localparam int LINE_W     = WORDS_PER_LINE * icache_pkg::WORD_W
) (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic [INDEX_W-1:0]                        rd_index,
   input  logic                                      wr_en,
   input  logic                                      wr_way,
   input  logic [INDEX_W-1:0]                        wr_index,
   input  logic [TAG_W-1:0]                          wr_tag,
   input  logic [LINE_W-1:0]                         wr_line,
   input  logic                                      lru_we,
   input  logic [INDEX_W-1:0]                        lru_index,
   input  logic                                      lru_val,
   output logic [icache_pkg::NUM_WAYS-1:0][TAG_W-1:0]  tags,
   output logic [icache_pkg::NUM_WAYS-1:0]             valids,
   output logic [icache_pkg::NUM_WAYS-1:0][LINE_W-1:0] lines,
   output logic                                      lru
);

   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [LINE_W-1:0] line_t;

   tag_t                tag_mem   [icache_pkg::NUM_WAYS][NUM_SETS];
   line_t               line_mem  [icache_pkg::NUM_WAYS][NUM_SETS];
   logic [NUM_SETS-1:0] valid_mem [icache_pkg::NUM_WAYS];
   logic [NUM_SETS-1:0] lru_mem;

   // tag and line storage, registered read
   always_ff @(posedge clk) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
         if (wr_en && int'(wr_way) == w) begin
            tag_mem[w][wr_index]  <= wr_tag;
            line_mem[w][wr_index] <= wr_line;
         end
         tags[w]  <= tag_mem[w][rd_index];
         lines[w] <= line_mem[w][rd_index];
      end
   end

   // valid and lru bits, cleared on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            valid_mem[w] <= '0;
         end
         lru_mem <= '0;
         valids  <= '0;
         lru     <= 1'b0;
      end else begin
         for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            // a line fill makes that way valid
            if (wr_en && int'(wr_way) == w) begin
               valid_mem[w][wr_index] <= 1'b1;
            end
            valids[w] <= valid_mem[w][rd_index];
         end
         if (lru_we) begin
            lru_mem[lru_index] <= lru_val;
         end
         lru <= lru_mem[rd_index];
      end
   end

endmodule

`default_nettype wire

/* logic/tag_lookup.sv */
`default_nettype none
`timescale 1ns/10ps

module tag_lookup #(
   parameter int WORDS_PER_LINE = 16,
   parameter int NUM_SETS       = 32,
   localparam int INDEX_W    = $clog2(NUM_SETS),
   localparam int WORD_OFS_W = $clog2(WORDS_PER_LINE),
   localparam int TAG_W      = icache_pkg::ADDR_W - INDEX_W - WORD_OFS_W - icache_pkg::BYTE_OFS_W,
   localparam int LINE_W     = WORDS_PER_LINE * icache_pkg::WORD_W
) (
   input  logic [TAG_W-1:0]                          tag,
   input  logic [WORD_OFS_W-1:0]                     word_sel,
   input  logic [icache_pkg::NUM_WAYS-1:0][TAG_W-1:0]  tags,
   input  logic [icache_pkg::NUM_WAYS-1:0]             valids,
   input  logic [icache_pkg::NUM_WAYS-1:0][LINE_W-1:0] lines,
   input  logic                                      lru,
   output logic                                      hit,
   output logic                                      hit_way,
   output icache_pkg::word_t                         hit_word,
   output logic                                      victim_way
);

   logic [icache_pkg::NUM_WAYS-1:0] match;
   logic [LINE_W-1:0]               hit_line;

   // per-way tag compare
   always_comb begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
         match[w] = valids[w] && (tags[w] == tag);
      end
   end

   assign hit     = |match;
   assign hit_way = match[1];

   // word out of the matching line
   assign hit_line = lines[hit_way];
   assign hit_word = hit_line[word_sel * icache_pkg::WORD_W +: icache_pkg::WORD_W];

   // lru bit names the way to replace
   assign victim_way = lru;

   // a line is filled into one way only, so a tag never lives in both
   a_single_hit: assert final ($isunknown(match) || $onehot0(match))
      else $error("tag_lookup: both ways hit for tag %h", tag);

endmodule

`default_nettype wire

/* logic/line_refill.sv */
`default_nettype none
`timescale 1ns/10ps

module line_refill #(
   parameter int WORDS_PER_LINE = 16,
   localparam int WORD_OFS_W = $clog2(WORDS_PER_LINE),
   localparam int LINE_W     = WORDS_PER_LINE * icache_pkg::WORD_W
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        start,
   input  icache_pkg::addr_t           line_base,
   input  logic [WORD_OFS_W-1:0]       word_sel,
   output icache_pkg::wb_req_t         mem_req,
   input  icache_pkg::wb_rsp_t         mem_rsp,
   output logic                        done,
   output logic [LINE_W-1:0]           line,
   output icache_pkg::word_t           req_word
);

   localparam icache_pkg::addr_t WORD_STEP = icache_pkg::addr_t'(1 << icache_pkg::BYTE_OFS_W);

   logic                    busy;
   logic [WORD_OFS_W-1:0]   count;
   icache_pkg::addr_t       adr_q;
   logic                    last;

   assign last = (count == WORD_OFS_W'(WORDS_PER_LINE - 1));

   // one open transfer at a time, cyc and stb together
   assign mem_req = '{cyc: busy, stb: busy, adr: adr_q};

   // transfer sequencing
   always_ff @(posedge clk) begin
      if (reset) begin
         busy  <= 1'b0;
         count <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            busy  <= 1'b1;
            count <= '0;
         end else if (busy && mem_rsp.ack) begin
            count <= count + 1'b1;
            if (last) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

   // address walk and line assembly
   always_ff @(posedge clk) begin
      if (start) begin
         adr_q <= line_base;
      end else if (busy && mem_rsp.ack) begin
         adr_q <= adr_q + WORD_STEP;
         // words arrive in ascending order, shift in from the top
         line  <= {mem_rsp.dat, line[LINE_W-1:icache_pkg::WORD_W]};
         if (count == word_sel) begin
            req_word <= mem_rsp.dat;
         end
      end
   end

   // classic handshake: request held with a stable address until ack
   a_stb_held: assert property (@(posedge clk) disable iff (reset)
      mem_req.stb && !mem_rsp.ack |=> mem_req.stb && $stable(mem_req.adr))
      else $error("line_refill: mem stb dropped or adr changed before ack");

endmodule

`default_nettype wire

/* logic/icache_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module icache_ctrl #(
   parameter int WORDS_PER_LINE = 16,
   parameter int NUM_SETS       = 32,
   localparam int INDEX_W    = $clog2(NUM_SETS),
   localparam int WORD_OFS_W = $clog2(WORDS_PER_LINE),
   localparam int LINE_OFS_W = WORD_OFS_W + icache_pkg::BYTE_OFS_W,
   localparam int TAG_W      = icache_pkg::ADDR_W - INDEX_W - LINE_OFS_W
) (
   input  logic                   clk,
   input  logic                   reset,
   input  icache_pkg::wb_req_t    cpu_req,
   output icache_pkg::wb_rsp_t    cpu_rsp,
   input  logic                   hit,
   input  logic                   hit_way,
   input  icache_pkg::word_t      hit_word,
   input  logic                   victim_way,
   input  logic                   refill_done,
   input  icache_pkg::word_t      req_word,
   output logic                   refill_start,
   output icache_pkg::addr_t      line_base,
   output logic [INDEX_W-1:0]     rd_index,
   output logic [TAG_W-1:0]       tag,
   output logic [WORD_OFS_W-1:0]  word_sel,
   output logic                   wr_en,
   output logic                   wr_way,
   output logic [INDEX_W-1:0]     wr_index,
   output logic                   lru_we,
   output logic [INDEX_W-1:0]     lru_index,
   output logic                   lru_val
);

   icache_pkg::ctrl_state_t state;
   icache_pkg::ctrl_state_t state_nxt;
   icache_pkg::addr_t       addr_q;
   logic [INDEX_W-1:0]      index;
   logic                    victim_q;
   logic                    accept;
   logic                    lookup_hit;

   assign accept     = (state == icache_pkg::st_idle) && cpu_req.cyc && cpu_req.stb;
   assign lookup_hit = (state == icache_pkg::st_lookup) && hit;

   always_comb begin
      state_nxt = state;
      case (state)
         icache_pkg::st_idle:    if (accept) state_nxt = icache_pkg::st_lookup;
         icache_pkg::st_lookup:  state_nxt = hit ? icache_pkg::st_idle : icache_pkg::st_refill;
         icache_pkg::st_refill:  if (refill_done) state_nxt = icache_pkg::st_respond;
         icache_pkg::st_respond: state_nxt = icache_pkg::st_idle;
         default:                state_nxt = icache_pkg::st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= icache_pkg::st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // request address and victim held for the whole miss
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= cpu_req.adr;
      end
      if (state == icache_pkg::st_lookup) begin
         victim_q <= victim_way;
      end
   end

   // address split
   assign tag       = addr_q[icache_pkg::ADDR_W-1 -: TAG_W];
   assign index     = addr_q[LINE_OFS_W +: INDEX_W];
   assign word_sel  = addr_q[icache_pkg::BYTE_OFS_W +: WORD_OFS_W];
   assign line_base = {addr_q[icache_pkg::ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};

   // arrays see the bus address while idle so data is ready in lookup
   assign rd_index = (state == icache_pkg::st_idle) ? cpu_req.adr[LINE_OFS_W +: INDEX_W] : index;

   assign refill_start = (state == icache_pkg::st_lookup) && !hit;

   // line write into the victim once the refill is done
   assign wr_en    = (state == icache_pkg::st_refill) && refill_done;
   assign wr_way   = victim_q;
   assign wr_index = index;

   // the way just used stops being the victim
   assign lru_we    = lookup_hit || wr_en;
   assign lru_index = index;
   assign lru_val   = (state == icache_pkg::st_lookup) ? ~hit_way : ~victim_q;

   assign cpu_rsp = '{
      ack: lookup_hit || (state == icache_pkg::st_respond),
      dat: (state == icache_pkg::st_respond) ? req_word : hit_word
   };

   // ack closes the request that the CPU is still holding
   a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
      cpu_rsp.ack |-> cpu_req.stb)
      else $error("icache_ctrl: cpu ack without cpu stb");

endmodule

`default_nettype wire

/* logic/icache_top.sv */
`default_nettype none
`timescale 1ns/10ps

module icache_top #(
   parameter int WORDS_PER_LINE = 16,
   parameter int NUM_SETS       = 32,
   localparam int INDEX_W    = $clog2(NUM_SETS),
   localparam int WORD_OFS_W = $clog2(WORDS_PER_LINE),
   localparam int TAG_W      = icache_pkg::ADDR_W - INDEX_W - WORD_OFS_W - icache_pkg::BYTE_OFS_W,
   localparam int LINE_W     = WORDS_PER_LINE * icache_pkg::WORD_W
) (
   input  logic                 clk,
   input  logic                 reset,
   input  icache_pkg::wb_req_t  cpu_req,
   output icache_pkg::wb_rsp_t  cpu_rsp,
   output icache_pkg::wb_req_t  mem_req,
   input  icache_pkg::wb_rsp_t  mem_rsp
);

   // array read side
   logic [INDEX_W-1:0]                          rd_index;
   logic [icache_pkg::NUM_WAYS-1:0][TAG_W-1:0]  tags;
   logic [icache_pkg::NUM_WAYS-1:0]             valids;
   logic [icache_pkg::NUM_WAYS-1:0][LINE_W-1:0] lines;
   logic                                        lru;

   // array write side
   logic                 wr_en;
   logic                 wr_way;
   logic [INDEX_W-1:0]   wr_index;
   logic                 lru_we;
   logic [INDEX_W-1:0]   lru_index;
   logic                 lru_val;

   // lookup results
   logic                 hit;
   logic                 hit_way;
   icache_pkg::word_t    hit_word;
   logic                 victim_way;

   // refill handshake
   logic                 refill_start;
   logic                 refill_done;
   icache_pkg::addr_t    line_base;
   logic [LINE_W-1:0]    refill_line;
   icache_pkg::word_t    req_word;

   logic [TAG_W-1:0]      tag;
   logic [WORD_OFS_W-1:0] word_sel;

   icache_ctrl #(
      .WORDS_PER_LINE(WORDS_PER_LINE),
      .NUM_SETS      (NUM_SETS)
   ) i_ctrl (
      .clk          (clk),
      .reset        (reset),
      .cpu_req      (cpu_req),
      .cpu_rsp      (cpu_rsp),
      .hit          (hit),
      .hit_way      (hit_way),
      .hit_word     (hit_word),
      .victim_way   (victim_way),
      .refill_done  (refill_done),
      .req_word     (req_word),
      .refill_start (refill_start),
      .line_base    (line_base),
      .rd_index     (rd_index),
      .tag          (tag),
      .word_sel     (word_sel),
      .wr_en        (wr_en),
      .wr_way       (wr_way),
      .wr_index     (wr_index),
      .lru_we       (lru_we),
      .lru_index    (lru_index),
      .lru_val      (lru_val)
   );

   cache_arrays #(
      .WORDS_PER_LINE(WORDS_PER_LINE),
      .NUM_SETS      (NUM_SETS)
   ) i_arrays (
      .clk       (clk),
      .reset     (reset),
      .rd_index  (rd_index),
      .wr_en     (wr_en),
      .wr_way    (wr_way),
      .wr_index  (wr_index),
      .wr_tag    (tag),
      .wr_line   (refill_line),
      .lru_we    (lru_we),
      .lru_index (lru_index),
      .lru_val   (lru_val),
      .tags      (tags),
      .valids    (valids),
      .lines     (lines),
      .lru       (lru)
   );

   tag_lookup #(
      .WORDS_PER_LINE(WORDS_PER_LINE),
      .NUM_SETS      (NUM_SETS)
   ) i_lookup (
      .tag        (tag),
      .word_sel   (word_sel),
      .tags       (tags),
      .valids     (valids),
      .lines      (lines),
      .lru        (lru),
      .hit        (hit),
      .hit_way    (hit_way),
      .hit_word   (hit_word),
      .victim_way (victim_way)
   );

   line_refill #(
      .WORDS_PER_LINE(WORDS_PER_LINE)
   ) i_refill (
      .clk       (clk),
      .reset     (reset),
      .start     (refill_start),
      .line_base (line_base),
      .word_sel  (word_sel),
      .mem_req   (mem_req),
      .mem_rsp   (mem_rsp),
      .done      (refill_done),
      .line      (refill_line),
      .req_word  (req_word)
   );

endmodule

`default_nettype wire

/* tests/wb_mem_model.sv */
`default_nettype none
`timescale 1ns/10ps

module wb_mem_model #(
   parameter int MAX_WAIT = 3
) (
   input  logic                clk,
   input  logic                reset,
   input  icache_pkg::wb_req_t req,
   output icache_pkg::wb_rsp_t rsp
);

   // wait states left before the next ack
   int unsigned waits_left;

   always_ff @(posedge clk) begin
      if (reset) begin
         rsp.ack    <= 1'b0;
         rsp.dat    <= '0;
         waits_left <= 0;
      end else if (rsp.ack) begin
         // single cycle ack, the held request is the next transfer
         rsp.ack <= 1'b0;
      end else if (req.cyc && req.stb) begin
         if (waits_left == 0) begin
            rsp.ack    <= 1'b1;
            // memory content is the inverted byte address
            rsp.dat    <= ~req.adr;
            waits_left <= $urandom_range(MAX_WAIT, 0);
         end else begin
            waits_left <= waits_left - 1;
         end
      end
   end

endmodule

`default_nettype wire

/* tests/icache_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module icache_tb;

   localparam int WPL            = 16;
   localparam int SETS           = 32;
   localparam int CYCLES_PER_ROW = WPL * 5 + 10;
   // reset and idle checks before the first row
   localparam int SETUP_CYCLES   = 20;

   typedef struct packed {
      icache_pkg::addr_t addr;
      icache_pkg::word_t data;
      logic              refill;
   } row_t;

   logic                clk;
   logic                reset;
   icache_pkg::wb_req_t cpu_req;
   icache_pkg::wb_rsp_t cpu_rsp;
   icache_pkg::wb_req_t mem_req;
   icache_pkg::wb_rsp_t mem_rsp;

   row_t              rows[$];
   icache_pkg::addr_t cur_addr;
   int                mem_xfers;
   int                mem_cycles;

   icache_top #(
      .WORDS_PER_LINE(WPL),
      .NUM_SETS      (SETS)
   ) i_dut (
      .clk     (clk),
      .reset   (reset),
      .cpu_req (cpu_req),
      .cpu_rsp (cpu_rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   wb_mem_model i_mem (
      .clk   (clk),
      .reset (reset),
      .req   (mem_req),
      .rsp   (mem_rsp)
   );

   always #20 clk = ~clk;

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected) begin
         $display("Fail %0t: %s, got %h, expected %h", $time, what, actual, expected);
         $display(">>> FAIL");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // word at byte address a holds ~a
   function automatic void add_row(input icache_pkg::addr_t a, input logic refill);
      rows.push_back('{addr: a, data: ~a, refill: refill});
   endfunction

   function automatic icache_pkg::addr_t line_start(input icache_pkg::addr_t a);
      return a & ~icache_pkg::addr_t'(WPL * 4 - 1);
   endfunction

   function automatic void build_table();
      // cold miss then the rest of the line as hits
      add_row(32'h0000_0104, 1'b1);
      add_row(32'h0000_0104, 1'b0);
      for (int w = 0; w < WPL; w++) begin
         if (w != 1) begin
            add_row(32'h0000_0100 + 4 * w, 1'b0);
         end
      end
      // lines A B and C share set 1 with a set stride of 0x800
      add_row(32'h0000_1040, 1'b1);
      add_row(32'h0000_1840, 1'b1);
      add_row(32'h0000_1040, 1'b0);
      add_row(32'h0000_2040, 1'b1);
      add_row(32'h0000_104c, 1'b0);
      add_row(32'h0000_1848, 1'b1);
      // two lines filling both ways of the last set
      add_row(32'h8000_07fc, 1'b1);
      add_row(32'hffff_ffc0, 1'b1);
      add_row(32'h8000_07c0, 1'b0);
      add_row(32'hffff_fffc, 1'b0);
   endfunction

   // every completed memory transfer must walk the line upward
   always @(negedge clk) begin
      if (!reset && mem_req.cyc) begin
         mem_cycles = mem_cycles + 1;
      end
      if (!reset && mem_req.cyc && mem_req.stb && mem_rsp.ack) begin
         check(mem_req.adr, line_start(cur_addr) + 4 * mem_xfers, "refill address order");
         mem_xfers = mem_xfers + 1;
      end
   end

   task automatic run_row(input row_t r, input int idx);
      int cycles;
      cycles     = 0;
      cur_addr   = r.addr;
      mem_xfers  = 0;
      mem_cycles = 0;
      cpu_req    = '{cyc: 1'b1, stb: 1'b1, adr: r.addr};
      do begin
         @(negedge clk);
         cycles++;
      end while (!cpu_rsp.ack);
      check(cpu_rsp.dat, r.data, $sformatf("row %0d data at %h", idx, r.addr));
      if (r.refill) begin
         check(mem_xfers, WPL, $sformatf("row %0d memory transfers", idx));
         // time on the memory bus plus at least three more cycles
         check(cycles >= mem_cycles + 3, 1,
               $sformatf("row %0d miss latency %0d over %0d bus cycles",
                         idx, cycles, mem_cycles));
      end else begin
         check(mem_xfers, 0, $sformatf("row %0d memory transfers", idx));
         // ack in the cycle after acceptance
         check(cycles, 2, $sformatf("row %0d hit latency", idx));
      end
      @(posedge clk);
      #2 cpu_req = '0;
      @(posedge clk);
      #2;
   endtask

   initial begin
      void'($urandom(32'h3951becb));
      clk        = 1'b0;
      reset      = 1'b1;
      cpu_req    = '0;
      cur_addr   = '0;
      mem_xfers  = 0;
      mem_cycles = 0;
      build_table();
      repeat (2) @(posedge clk);
      #2 reset = 1'b0;
      // quiet bus after reset
      repeat (5) begin
         @(negedge clk);
         check(cpu_rsp.ack, 0, "cpu ack after reset");
         check(mem_req.cyc, 0, "mem cyc after reset");
         check(mem_req.stb, 0, "mem stb after reset");
      end
      @(posedge clk);
      #2;
      foreach (rows[i]) begin
         run_row(rows[i], i);
      end
      $display(">>> PASS");
      $finish;
   end

   initial begin
      #1;
      repeat (SETUP_CYCLES + rows.size() * CYCLES_PER_ROW) @(posedge clk);
      $display("watchdog expired, a cache request was never acknowledged");
      $display(">>> FAIL");
      $fatal(1, "run aborted by the watchdog");
   end

endmodule

`default_nettype wire

/* vlog.f */
logic/icache_pkg.sv
logic/cache_arrays.sv
logic/tag_lookup.sv
logic/line_refill.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tests/wb_mem_model.sv
tests/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - logic/icache_pkg.sv
      - logic/cache_arrays.sv
      - logic/tag_lookup.sv
      - logic/line_refill.sv
      - logic/icache_ctrl.sv
      - logic/icache_top.sv
  - target: test
    files:
      - tests/wb_mem_model.sv
      - tests/icache_tb.sv

# testbench top: icache_tb
# design top: icache_top
# file list for direct compiles: vlog.f
